// ==== lsu_cfg.svh ====
//*********************************************************************
// Cache geometry and address map of the load/store unit
// The geometry is fixed here and no module takes a parameter
// LsuLineBytes must be a power of two
// Index, offset and tag widths must add up to LsuAddrWidth
//*********************************************************************

`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Bytes per cache line
`define LsuLineBytes 16

// 16 lines in the direct-mapped cache
`define LsuIndexWidth 4

// Physical address bits in use
`define LsuAddrWidth 16

// Store target of the host I/O debug register
`define LsuHostIoAddr 16'hFFF0

`endif

// ==== lsuPkg.sv ====
//*********************************************************************
// Shared vector types and enums of the load/store unit
// Widths follow the cache geometry macros
//*********************************************************************

`include "lsu_cfg.svh"

package lsuPkg;
    localparam int OffsetWidth = $clog2(`LsuLineBytes);
    localparam int TagWidth = `LsuAddrWidth - `LsuIndexWidth - OffsetWidth;

    typedef logic [31:0] word_t;
    typedef logic [`LsuAddrWidth-1:0] paddr_t;
    typedef logic [`LsuAddrWidth-OffsetWidth-1:0] lineAddr_t;
    typedef logic [`LsuIndexWidth-1:0] index_t;
    typedef logic [TagWidth-1:0] tag_t;
    typedef logic [OffsetWidth-1:0] offset_t;
    typedef logic [`LsuLineBytes*8-1:0] line_t;
    typedef logic [`LsuLineBytes-1:0] writeMask_t;

    typedef enum logic [1:0] {
        LsuCmdNone       = 2'h0,
        LsuCmdLoad       = 2'h1,
        LsuCmdStore      = 2'h2,
        LsuCmdInvalidate = 2'h3
    } lsuCommand_t;

    typedef enum logic [2:0] {
        LsTypeWord             = 3'h0,
        LsTypeHalfWord         = 3'h1,
        LsTypeUnsignedHalfWord = 3'h2,
        LsTypeByte             = 3'h3,
        LsTypeUnsignedByte     = 3'h4
    } loadStoreType_t;

    typedef enum logic [1:0] {
        CacheCmdNone         = 2'h0,
        CacheCmdReplace      = 2'h1,
        CacheCmdWriteThrough = 2'h2,
        CacheCmdInvalidate   = 2'h3
    } cacheCommand_t;

    typedef enum logic [2:0] {
        StateDefault      = 3'h0,
        StateLoad         = 3'h1,
        StateStore        = 3'h2,
        StateReplaceCache = 3'h3,
        StateWriteThrough = 3'h4,
        StateInvalidate   = 3'h5
    } lsuState_t;
endpackage

// ==== accessAligner.sv ====
//*********************************************************************
// Byte-lane alignment between a cache line and a 32-bit access
// Purely combinational
// Accesses must be naturally aligned, a misaligned access is not
// supported and gives undefined data
//*********************************************************************

`timescale 1ns/1ps

`include "lsu_cfg.svh"

module accessAligner (
    input  lsuPkg::offset_t        offset,
    input  lsuPkg::loadStoreType_t loadStoreType,
    input  lsuPkg::line_t          lineData,
    input  lsuPkg::word_t          storeValue,
    output lsuPkg::word_t          loadResult,
    output lsuPkg::line_t          storeLine,
    output lsuPkg::writeMask_t     storeMask
);
    import lsuPkg::*;

    word_t      shiftedWord;
    logic [3:0] byteMask;

    // Addressed bytes moved down to lane zero
    always_comb begin
        shiftedWord = '0;
        for (int i = 0; i < 4; i++) begin
            if (int'(offset) + i < `LsuLineBytes) begin
                shiftedWord[8*i +: 8] = lineData[8*(int'(offset) + i) +: 8];
            end
        end
    end

    always_comb begin
        case (loadStoreType)
            LsTypeHalfWord: begin
                loadResult = {{16{shiftedWord[15]}}, shiftedWord[15:0]};
            end
            LsTypeUnsignedHalfWord: begin
                loadResult = {16'h0000, shiftedWord[15:0]};
            end
            LsTypeByte: begin
                loadResult = {{24{shiftedWord[7]}}, shiftedWord[7:0]};
            end
            LsTypeUnsignedByte: begin
                loadResult = {24'h000000, shiftedWord[7:0]};
            end
            default: begin
                loadResult = shiftedWord;
            end
        endcase
    end

    // Lanes written by the store, before the offset shift
    always_comb begin
        case (loadStoreType)
            LsTypeHalfWord, LsTypeUnsignedHalfWord: begin
                byteMask = 4'b0011;
            end
            LsTypeByte, LsTypeUnsignedByte: begin
                byteMask = 4'b0001;
            end
            default: begin
                byteMask = 4'b1111;
            end
        endcase
    end

    // Unused upper lanes of the word are masked off anyway
    assign storeLine = line_t'(storeValue) << {offset, 3'b000};
    assign storeMask = writeMask_t'(byteMask) << offset;
endmodule

// ==== dcacheArrays.sv ====
//*********************************************************************
// Valid/tag array and byte-banked data array of the data cache
// Reads are registered and return the old contents on a write
// Only the valid bits are cleared by reset
//*********************************************************************

`timescale 1ns/1ps

`include "lsu_cfg.svh"

module dcacheArrays (
    input  logic               clk,
    input  logic               rst,
    input  lsuPkg::index_t     index,
    input  logic               tagWriteEnable,
    input  logic               tagWriteValid,
    input  lsuPkg::tag_t       tagWriteTag,
    input  lsuPkg::writeMask_t dataWriteMask,
    input  lsuPkg::line_t      dataWriteValue,
    output logic               readValid,
    output lsuPkg::tag_t       readTag,
    output lsuPkg::line_t      readData
);
    import lsuPkg::*;

    localparam int Depth = 1 << `LsuIndexWidth;

    logic [Depth-1:0] validBits;
    tag_t             tagArray [Depth];

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
            readValid <= 1'b0;
        end else begin
            if (tagWriteEnable) begin
                validBits[index] <= tagWriteValid;
            end
            readValid <= validBits[index];
        end
    end

    always_ff @(posedge clk) begin
        if (tagWriteEnable) begin
            tagArray[index] <= tagWriteTag;
        end
        readTag <= tagArray[index];
    end

    // One bank per line byte, each under its own mask bit
    for (genvar b = 0; b < `LsuLineBytes; b++) begin : gBank
        logic [7:0] bank [Depth];
        logic [7:0] bankRead;

        always_ff @(posedge clk) begin
            if (dataWriteMask[b]) begin
                bank[index] <= dataWriteValue[8*b +: 8];
            end
            bankRead <= bank[index];
        end

        assign readData[8*b +: 8] = bankRead;
    end
endmodule

// ==== lineReplacer.sv ====
//*********************************************************************
// Line sequencer between the cache arrays and the memory port
// Replace refills one line, WriteThrough copies one line out and
// Invalidate clears every valid bit, one index per cycle
// The command must stay steady until done
// A memory request stays high until its grant pulse
//*********************************************************************

`timescale 1ns/1ps

`include "lsu_cfg.svh"

module lineReplacer (
    input  logic                  clk,
    input  logic                  rst,
    input  lsuPkg::cacheCommand_t cacheCommand,
    input  lsuPkg::lineAddr_t     lineAddr,
    input  lsuPkg::line_t         arrayReadData,
    output lsuPkg::lineAddr_t     memAddr,
    output logic                  memReadReq,
    output logic                  memWriteReq,
    output lsuPkg::line_t         memWriteValue,
    input  logic                  memReadGrant,
    input  lsuPkg::line_t         memReadValue,
    input  logic                  memWriteGrant,
    output lsuPkg::index_t        arrayIndex,
    output logic                  arrayWriteEnable,
    output logic                  arrayWriteValid,
    output lsuPkg::tag_t          arrayWriteTag,
    output lsuPkg::line_t         arrayWriteData,
    output logic                  done
);
    import lsuPkg::*;

    index_t sweepIndex;
    logic   writeArmed;

    always_ff @(posedge clk) begin
        if (rst) begin
            sweepIndex <= '0;
            writeArmed <= 1'b0;
        end else begin
            // Each sweep starts again at index zero
            if (cacheCommand == CacheCmdInvalidate) begin
                sweepIndex <= sweepIndex + 1'b1;
            end else begin
                sweepIndex <= '0;
            end

            // Store data reaches the registered array read one cycle late
            writeArmed <= (cacheCommand == CacheCmdWriteThrough) && !memWriteGrant;
        end
    end

    assign memAddr = lineAddr;
    assign memWriteValue = arrayReadData;
    assign arrayWriteTag = lineAddr[$bits(lineAddr_t)-1 -: TagWidth];
    assign arrayWriteData = memReadValue;

    always_comb begin
        memReadReq = 1'b0;
        memWriteReq = 1'b0;
        arrayIndex = lineAddr[`LsuIndexWidth-1:0];
        arrayWriteEnable = 1'b0;
        arrayWriteValid = 1'b0;
        done = 1'b0;

        case (cacheCommand)
            CacheCmdReplace: begin
                memReadReq = 1'b1;
                // Data, tag and valid bit land together with the grant
                arrayWriteEnable = memReadGrant;
                arrayWriteValid = 1'b1;
                done = memReadGrant;
            end
            CacheCmdWriteThrough: begin
                memWriteReq = writeArmed;
                done = writeArmed && memWriteGrant;
            end
            CacheCmdInvalidate: begin
                arrayIndex = sweepIndex;
                arrayWriteEnable = 1'b1;
                done = &sweepIndex;
            end
            default: begin
                done = 1'b0;
            end
        endcase
    end
endmodule

// ==== loadStoreUnit.sv ====
//*********************************************************************
// Data-side load/store unit with a direct-mapped write-through cache
// Addresses are physical and accesses must be naturally aligned
// The requester holds its inputs from enable until the done pulse
// and drops enable in the cycle after done
// Every store writes the whole line through to memory
//*********************************************************************

`timescale 1ns/1ps

`include "lsu_cfg.svh"

module loadStoreUnit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enable,
    input  lsuPkg::lsuCommand_t    command,
    input  lsuPkg::loadStoreType_t loadStoreType,
    input  lsuPkg::paddr_t         addr,
    input  lsuPkg::word_t          storeValue,
    output logic                   done,
    output lsuPkg::word_t          result,
    output lsuPkg::word_t          hostIoValue,
    output lsuPkg::lineAddr_t      memAddr,
    output logic                   memReadReq,
    output logic                   memWriteReq,
    output lsuPkg::line_t          memWriteValue,
    input  logic                   memReadGrant,
    input  lsuPkg::line_t          memReadValue,
    input  logic                   memWriteGrant
);
    import lsuPkg::*;

    lsuState_t      state;
    lsuState_t      nextState;
    paddr_t         rAddr;
    loadStoreType_t rType;
    word_t          rStoreValue;

    logic           cacheMiss;
    cacheCommand_t  replacerCommand;
    logic           replacerDone;
    index_t         replacerIndex;
    logic           replacerWriteEnable;
    logic           replacerWriteValid;
    tag_t           replacerWriteTag;
    line_t          replacerWriteData;

    index_t         arrayIndex;
    logic           tagWriteEnable;
    logic           tagWriteValid;
    tag_t           tagWriteTag;
    writeMask_t     dataWriteMask;
    line_t          dataWriteValue;
    logic           readValid;
    tag_t           readTag;
    line_t          readData;
    line_t          storeLine;
    writeMask_t     storeMask;

    dcacheArrays u_arrays (
        .clk            (clk),
        .rst            (rst),
        .index          (arrayIndex),
        .tagWriteEnable (tagWriteEnable),
        .tagWriteValid  (tagWriteValid),
        .tagWriteTag    (tagWriteTag),
        .dataWriteMask  (dataWriteMask),
        .dataWriteValue (dataWriteValue),
        .readValid      (readValid),
        .readTag        (readTag),
        .readData       (readData)
    );

    lineReplacer u_replacer (
        .clk              (clk),
        .rst              (rst),
        .cacheCommand     (replacerCommand),
        .lineAddr         (rAddr[`LsuAddrWidth-1:OffsetWidth]),
        .arrayReadData    (readData),
        .memAddr          (memAddr),
        .memReadReq       (memReadReq),
        .memWriteReq      (memWriteReq),
        .memWriteValue    (memWriteValue),
        .memReadGrant     (memReadGrant),
        .memReadValue     (memReadValue),
        .memWriteGrant    (memWriteGrant),
        .arrayIndex       (replacerIndex),
        .arrayWriteEnable (replacerWriteEnable),
        .arrayWriteValid  (replacerWriteValid),
        .arrayWriteTag    (replacerWriteTag),
        .arrayWriteData   (replacerWriteData),
        .done             (replacerDone)
    );

    accessAligner u_aligner (
        .offset        (rAddr[OffsetWidth-1:0]),
        .loadStoreType (rType),
        .lineData      (readData),
        .storeValue    (rStoreValue),
        .loadResult    (result),
        .storeLine     (storeLine),
        .storeMask     (storeMask)
    );

    // Array outputs belong to the address registered in the accept cycle
    assign cacheMiss = !readValid || (readTag != rAddr[`LsuAddrWidth-1 -: TagWidth]);

    always_comb begin
        case (state)
            StateReplaceCache: replacerCommand = CacheCmdReplace;
            StateWriteThrough: replacerCommand = CacheCmdWriteThrough;
            StateInvalidate:   replacerCommand = CacheCmdInvalidate;
            default:           replacerCommand = CacheCmdNone;
        endcase
    end

    always_comb begin
        nextState = state;
        done = 1'b0;
        case (state)
            StateDefault: begin
                if (enable) begin
                    case (command)
                        LsuCmdLoad:       nextState = StateLoad;
                        LsuCmdStore:      nextState = StateStore;
                        LsuCmdInvalidate: nextState = StateInvalidate;
                        default:          nextState = StateDefault;
                    endcase
                end
            end
            StateLoad: begin
                nextState = cacheMiss ? StateReplaceCache : StateDefault;
                done = !cacheMiss;
            end
            StateStore: begin
                nextState = cacheMiss ? StateReplaceCache : StateWriteThrough;
            end
            StateReplaceCache: begin
                // Back to Default, which accepts the held command again
                if (replacerDone) begin
                    nextState = StateDefault;
                end
            end
            StateWriteThrough, StateInvalidate: begin
                if (replacerDone) begin
                    nextState = StateDefault;
                end
                done = replacerDone;
            end
            default: begin
                nextState = StateDefault;
            end
        endcase
    end

    // Array steering between the replacer and the access pipeline
    always_comb begin
        if (state == StateReplaceCache || state == StateInvalidate) begin
            arrayIndex = replacerIndex;
            tagWriteEnable = replacerWriteEnable;
            tagWriteValid = replacerWriteValid;
            tagWriteTag = replacerWriteTag;
        end else begin
            arrayIndex = (state == StateDefault) ? addr[OffsetWidth +: `LsuIndexWidth]
                                                 : rAddr[OffsetWidth +: `LsuIndexWidth];
            tagWriteEnable = 1'b0;
            tagWriteValid = 1'b0;
            tagWriteTag = '0;
        end

        if (state == StateReplaceCache) begin
            dataWriteMask = replacerWriteEnable ? '1 : '0;
            dataWriteValue = replacerWriteData;
        end else if (state == StateStore && !cacheMiss) begin
            dataWriteMask = storeMask;
            dataWriteValue = storeLine;
        end else begin
            dataWriteMask = '0;
            dataWriteValue = storeLine;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StateDefault;
            hostIoValue <= '0;
        end else begin
            state <= nextState;
            // Debug register follows completed stores to the host I/O address
            if (state == StateWriteThrough && replacerDone && rAddr == `LsuHostIoAddr) begin
                hostIoValue <= rStoreValue;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == StateDefault) begin
            rAddr <= addr;
            rType <= loadStoreType;
            rStoreValue <= storeValue;
        end
    end
endmodule

// ==== tbMemory.sv ====
//*********************************************************************
// Line-wide memory model for the load/store unit testbench
// 4096 lines, contents come only through the backdoor task
// Grants follow a request after 1 to 4 extra cycles
// Also holds the testbench LFSR, seed 44781, one step per bit
//*********************************************************************

`timescale 1ns/1ps

module tbMemory (
    input  logic              clk,
    input  logic              rst,
    input  lsuPkg::lineAddr_t addr,
    input  logic              readReq,
    input  logic              writeReq,
    input  lsuPkg::line_t     writeValue,
    output logic              readGrant,
    output lsuPkg::line_t     readValue,
    output logic              writeGrant
);
    import lsuPkg::*;

    localparam int Lines = 4096;

    line_t       lines [Lines];
    logic [15:0] lfsrState = 16'd44781;
    logic        pending;
    logic [1:0]  waitCount;

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    task automatic backdoorWrite(input lineAddr_t lineAddr, input line_t value);
        lines[lineAddr] <= value;
    endtask

    function automatic line_t backdoorRead(input lineAddr_t lineAddr);
        return lines[lineAddr];
    endfunction

    assign readValue = lines[addr];

    always @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            waitCount <= 2'd0;
            readGrant <= 1'b0;
            writeGrant <= 1'b0;
        end else begin
            readGrant <= 1'b0;
            writeGrant <= 1'b0;
            if (writeGrant && writeReq) begin
                lines[addr] <= writeValue;
            end
            if (pending) begin
                if (waitCount == 2'd0) begin
                    pending <= 1'b0;
                    readGrant <= readReq;
                    writeGrant <= writeReq;
                end else begin
                    waitCount <= waitCount - 2'd1;
                end
            end else if ((readReq || writeReq) && !readGrant && !writeGrant) begin
                // New request, random extra wait
                pending <= 1'b1;
                waitCount <= 2'(randomBits(2));
            end
        end
    end
endmodule

// ==== tbLoadStoreUnit.sv ====
//*********************************************************************
// Testbench of the load/store unit
// A byte image of memory predicts every load and the host I/O value
// Stimulus changes 10 ns after each rising edge
// Stops at the first mismatch or when the cycle limit runs out
//*********************************************************************

`timescale 1ns/1ps

`include "lsu_cfg.svh"

module tbLoadStoreUnit;
    import lsuPkg::*;

    localparam int RandomRounds = 24;
    localparam int CommandCount = 6 + 6 * RandomRounds + 5 + 3;
    localparam int CycleLimit = 200 * CommandCount;
    localparam int ImageBytes = 1 << `LsuAddrWidth;

    logic           clk;
    logic           rst;
    logic           enable;
    lsuCommand_t    command;
    loadStoreType_t loadStoreType;
    paddr_t         addr;
    word_t          storeValue;
    logic           done;
    word_t          result;
    word_t          hostIoValue;
    lineAddr_t      memAddr;
    logic           memReadReq;
    logic           memWriteReq;
    line_t          memWriteValue;
    logic           memReadGrant;
    line_t          memReadValue;
    logic           memWriteGrant;

    logic [7:0]     refImage [ImageBytes];
    logic           expectLoad;
    word_t          expectedResult;
    word_t          expectedHostIo;
    logic           hostCheckDue = 1'b0;
    int             completedCount = 0;
    int             cycleCount = 0;
    int             lastLatency;

    loadStoreUnit u_dut (
        .clk           (clk),
        .rst           (rst),
        .enable        (enable),
        .command       (command),
        .loadStoreType (loadStoreType),
        .addr          (addr),
        .storeValue    (storeValue),
        .done          (done),
        .result        (result),
        .hostIoValue   (hostIoValue),
        .memAddr       (memAddr),
        .memReadReq    (memReadReq),
        .memWriteReq   (memWriteReq),
        .memWriteValue (memWriteValue),
        .memReadGrant  (memReadGrant),
        .memReadValue  (memReadValue),
        .memWriteGrant (memWriteGrant)
    );

    tbMemory u_mem (
        .clk        (clk),
        .rst        (rst),
        .addr       (memAddr),
        .readReq    (memReadReq),
        .writeReq   (memWriteReq),
        .writeValue (memWriteValue),
        .readGrant  (memReadGrant),
        .readValue  (memReadValue),
        .writeGrant (memWriteGrant)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stopWithFailure();
        $display("Result: FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    function automatic logic [7:0] patternByte(input int byteAddr);
        return 8'(byteAddr ^ (byteAddr >> 8) ^ 32'hA5);
    endfunction

    function automatic int accessBytes(input loadStoreType_t accessType);
        case (accessType)
            LsTypeHalfWord, LsTypeUnsignedHalfWord: return 2;
            LsTypeByte, LsTypeUnsignedByte: return 1;
            default: return 4;
        endcase
    endfunction

    function automatic loadStoreType_t typeFromIndex(input int index);
        case (index)
            1: return LsTypeHalfWord;
            2: return LsTypeUnsignedHalfWord;
            3: return LsTypeByte;
            4: return LsTypeUnsignedByte;
            default: return LsTypeWord;
        endcase
    endfunction

    // Expected load value, sign or zero extended by type
    function automatic word_t refLoad(input paddr_t byteAddr, input loadStoreType_t accessType);
        word_t raw;
        raw = '0;
        for (int i = 0; i < accessBytes(accessType); i++) begin
            raw[8*i +: 8] = refImage[int'(byteAddr) + i];
        end
        case (accessType)
            LsTypeHalfWord: return {{16{raw[15]}}, raw[15:0]};
            LsTypeUnsignedHalfWord: return {16'h0000, raw[15:0]};
            LsTypeByte: return {{24{raw[7]}}, raw[7:0]};
            LsTypeUnsignedByte: return {24'h000000, raw[7:0]};
            default: return raw;
        endcase
    endfunction

    task automatic refStore(input paddr_t byteAddr, input loadStoreType_t accessType,
                            input word_t value);
        for (int i = 0; i < accessBytes(accessType); i++) begin
            refImage[int'(byteAddr) + i] = value[8*i +: 8];
        end
    endtask

    function automatic line_t refLine(input lineAddr_t lineAddr);
        line_t line;
        for (int i = 0; i < `LsuLineBytes; i++) begin
            line[8*i +: 8] = refImage[int'(lineAddr) * `LsuLineBytes + i];
        end
        return line;
    endfunction

    task automatic setRefLine(input lineAddr_t lineAddr, input line_t line);
        for (int i = 0; i < `LsuLineBytes; i++) begin
            refImage[int'(lineAddr) * `LsuLineBytes + i] = line[8*i +: 8];
        end
    endtask

    // Four tags over all indexes, aligned to the access size
    function automatic paddr_t randomAddress(input loadStoreType_t accessType);
        logic [31:0] bits;
        paddr_t      byteAddr;
        bits = u_mem.randomBits(10);
        byteAddr = {6'b010000, bits[9:0]};
        if (accessBytes(accessType) == 4) begin
            byteAddr[1:0] = 2'b00;
        end else if (accessBytes(accessType) == 2) begin
            byteAddr[0] = 1'b0;
        end
        return byteAddr;
    endfunction

    // Holds the inputs until done, then one idle cycle with enable low
    task automatic runCommand(input lsuCommand_t cmd, input loadStoreType_t accessType,
                              input paddr_t accessAddr, input word_t value);
        int startCount;
        startCount = completedCount;
        expectLoad = (cmd == LsuCmdLoad);
        if (cmd == LsuCmdLoad) begin
            expectedResult = refLoad(accessAddr, accessType);
        end
        if (cmd == LsuCmdStore) begin
            refStore(accessAddr, accessType, value);
            if (accessAddr == `LsuHostIoAddr) begin
                expectedHostIo = value;
            end
        end
        command = cmd;
        loadStoreType = accessType;
        addr = accessAddr;
        storeValue = value;
        enable = 1'b1;
        lastLatency = 0;
        do begin
            @(posedge clk);
            #1;
            lastLatency++;
        end while (completedCount == startCount);
        #9;
        enable = 1'b0;
        command = LsuCmdNone;
        @(posedge clk);
        #10;
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: no finish within %0d cycles", CycleLimit);
            stopWithFailure();
        end
    end

    // Checks on every done, host I/O one cycle later
    always @(posedge clk) begin
        if (!rst) begin
            if (hostCheckDue) begin
                hostCheckDue <= 1'b0;
                assert (hostIoValue === expectedHostIo) else begin
                    $display("[ERROR] hostIoValue: expected 0x%08h, got 0x%08h",
                             expectedHostIo, hostIoValue);
                    stopWithFailure();
                end
            end
            if (done) begin
                assert (enable) else begin
                    $display("done pulsed while enable was low");
                    stopWithFailure();
                end
                if (expectLoad) begin
                    assert (result === expectedResult) else begin
                        $display("[ERROR] result: expected 0x%08h, got 0x%08h",
                                 expectedResult, result);
                        stopWithFailure();
                    end
                end
                hostCheckDue <= 1'b1;
                completedCount <= completedCount + 1;
            end
        end
    end

    initial begin
        line_t          fillLine;
        line_t          newLine;
        paddr_t         byteAddr;
        word_t          value;
        loadStoreType_t storeType;

        rst = 1'b1;
        enable = 1'b0;
        command = LsuCmdNone;
        loadStoreType = LsTypeWord;
        addr = '0;
        storeValue = '0;
        expectLoad = 1'b0;
        expectedResult = '0;
        expectedHostIo = '0;

        for (int la = 0; la < 4096; la++) begin
            for (int b = 0; b < `LsuLineBytes; b++) begin
                fillLine[8*b +: 8] = patternByte(la * `LsuLineBytes + b);
            end
            setRefLine(lineAddr_t'(la), fillLine);
            u_mem.backdoorWrite(lineAddr_t'(la), fillLine);
        end

        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;

        // Miss then hit on one line, all load types
        runCommand(LsuCmdLoad, LsTypeWord, 16'h1234, '0);
        runCommand(LsuCmdLoad, LsTypeWord, 16'h1234, '0);
        assert (lastLatency == 2) else begin
            $display("Load hit took %0d cycles from enable to done instead of 2",
                     lastLatency);
            stopWithFailure();
        end
        runCommand(LsuCmdLoad, LsTypeHalfWord, 16'h1236, '0);
        runCommand(LsuCmdLoad, LsTypeUnsignedHalfWord, 16'h1236, '0);
        runCommand(LsuCmdLoad, LsTypeByte, 16'h1237, '0);
        runCommand(LsuCmdLoad, LsTypeUnsignedByte, 16'h1237, '0);

        // Random stores, each read back with every load type
        for (int n = 0; n < RandomRounds; n++) begin
            storeType = typeFromIndex(int'(u_mem.randomBits(3)) % 5);
            byteAddr = randomAddress(storeType);
            value = u_mem.randomBits(32);
            runCommand(LsuCmdStore, storeType, byteAddr, value);
            runCommand(LsuCmdLoad, LsTypeWord, byteAddr & 16'hFFFC, '0);
            runCommand(LsuCmdLoad, LsTypeHalfWord, byteAddr & 16'hFFFE, '0);
            runCommand(LsuCmdLoad, LsTypeUnsignedHalfWord, byteAddr & 16'hFFFE, '0);
            runCommand(LsuCmdLoad, LsTypeByte, byteAddr, '0);
            runCommand(LsuCmdLoad, LsTypeUnsignedByte, byteAddr, '0);
        end

        // Write-through leaves memory equal to the image
        for (int la = 0; la < 4096; la++) begin
            assert (u_mem.backdoorRead(lineAddr_t'(la)) === refLine(lineAddr_t'(la))) else begin
                $display("[ERROR] memory line 0x%03h: expected 0x%032h, got 0x%032h", la,
                         refLine(lineAddr_t'(la)), u_mem.backdoorRead(lineAddr_t'(la)));
                stopWithFailure();
            end
        end

        // Stale line until invalidate
        runCommand(LsuCmdLoad, LsTypeWord, 16'h2340, '0);
        newLine = ~refLine(12'h234);
        u_mem.backdoorWrite(12'h234, newLine);
        runCommand(LsuCmdLoad, LsTypeWord, 16'h2340, '0);
        runCommand(LsuCmdInvalidate, LsTypeWord, 16'h0000, '0);
        setRefLine(12'h234, newLine);
        runCommand(LsuCmdLoad, LsTypeWord, 16'h2340, '0);
        runCommand(LsuCmdLoad, LsTypeByte, 16'h2347, '0);

        // Host I/O register
        value = u_mem.randomBits(32);
        runCommand(LsuCmdStore, LsTypeWord, `LsuHostIoAddr, value);
        runCommand(LsuCmdStore, LsTypeByte, 16'h4321, ~value);
        runCommand(LsuCmdLoad, LsTypeWord, `LsuHostIoAddr, '0);

        $display("Result: PASSED");
        $finish;
    end
endmodule

// ==== compile.f ====
+incdir+.
lsuPkg.sv
accessAligner.sv
dcacheArrays.sv
lineReplacer.sv
loadStoreUnit.sv
tbMemory.sv
tbLoadStoreUnit.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tbLoadStoreUnit
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The simulator status is hidden by tee, so the log decides
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
